//--- logic/ccm_pkg.sv
package ccm_pkg;

   // word and field widths
   localparam int DATA_W   = 32;
   localparam int ECC_W    = 7;
   localparam int OFFSET_W = 12;

   typedef logic [DATA_W-1:0]          addr_t;
   typedef logic [DATA_W-1:0]          data_t;
   typedef logic [ECC_W-1:0]           ecc_t;
   typedef logic signed [OFFSET_W-1:0] offset_t;

   // ccm placement
   localparam addr_t CCM_SADR    = 32'hF004_0000;
   localparam int    CCM_SIZE_KB = 64;
   localparam int    REGION_BITS = 4;                       // top nibble selects the region
   localparam int    MASK_BITS   = 10 + $clog2(CCM_SIZE_KB);

   // hamming masks, data bits at the non power of two codeword positions 1..38
   // mask k holds the data bits whose position has bit k set
   localparam logic [5:0][DATA_W-1:0] SYND_MASK = {
      32'hFC00_0000,   // check bit 5
      32'h03FF_F800,   // check bit 4
      32'h03FC_07F0,   // check bit 3
      32'hE3C3_C78E,   // check bit 2
      32'h9B33_366D,   // check bit 1
      32'h56AA_AD5B    // check bit 0
   };

   localparam int ERR_CNT_W = 8;

endpackage

//--- logic/ccm_addr_gen.sv
`timescale 1ns/10ps

module ccm_addr_gen (
   input  logic             clk,
   input  logic             rst_l,
   input  logic             req_valid,
   input  ccm_pkg::addr_t   rs1,
   input  ccm_pkg::offset_t offset,
   output logic             a_valid,
   output ccm_pkg::addr_t   a_addr,
   output logic             a_in_range,
   output logic             a_in_region
);

   logic [11:0]    sum_lo;
   logic           cout;
   logic           sign;
   logic [31:12]   rs1_inc;
   logic [31:12]   rs1_dec;
   ccm_pkg::addr_t eff_addr;
   logic           in_range;
   logic           in_region;

   // low 12 bits added directly, upper part picked from precomputed values
   assign {cout, sum_lo} = {1'b0, rs1[11:0]} + {1'b0, offset[ccm_pkg::OFFSET_W-1:0]};
   assign sign           = offset[ccm_pkg::OFFSET_W-1];
   assign rs1_inc        = rs1[31:12] + 20'd1;
   assign rs1_dec        = rs1[31:12] - 20'd1;

   assign eff_addr[11:0]  = sum_lo;
   assign eff_addr[31:12] = ({20{ sign ~^ cout}} & rs1[31:12]) |   // upper bits kept when sign and carry cancel
                            ({20{~sign &  cout}} & rs1_inc)    |
                            ({20{ sign & ~cout}} & rs1_dec);

   assign in_range  = eff_addr[31:ccm_pkg::MASK_BITS] ==
                      ccm_pkg::CCM_SADR[31:ccm_pkg::MASK_BITS];
   assign in_region = eff_addr[31 -: ccm_pkg::REGION_BITS] ==
                      ccm_pkg::CCM_SADR[31 -: ccm_pkg::REGION_BITS];

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         a_valid     <= 1'b0;
         a_in_range  <= 1'b0;
         a_in_region <= 1'b0;
      end else begin
         a_valid <= req_valid;
         if (req_valid) begin
            a_in_range  <= in_range;
            a_in_region <= in_region;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) a_addr <= eff_addr;
   end

endmodule

//--- logic/ccm_ecc_check.sv
`timescale 1ns/10ps

module ccm_ecc_check (
   input  logic           clk,
   input  logic           rst_l,
   input  logic           req_valid,
   input  logic           ecc_en,
   input  logic           sed_ded,    // detect only, every error reported as double
   input  ccm_pkg::data_t rdata,
   input  ccm_pkg::ecc_t  recc,
   output logic           d_valid,
   output ccm_pkg::data_t d_data,
   output ccm_pkg::ecc_t  d_ecc,
   output logic           d_single,
   output logic           d_double
);

   logic [6:0]     ecc_check;
   logic           err_any;
   logic           single_err;
   logic           double_err;
   logic           par_only;
   logic [38:0]    err_mask;
   logic [38:0]    cw;
   logic [38:0]    cw_fix;
   ccm_pkg::data_t data_fix;
   ccm_pkg::ecc_t  ecc_fix;

   // syndrome bits from the hamming masks
   always_comb begin
      for (int k = 0; k < 6; k++) begin
         ecc_check[k] = recc[k] ^ (^(rdata & ccm_pkg::SYND_MASK[k]));
      end
      ecc_check[6] = ((^rdata) ^ (^recc)) & ~sed_ded;   // overall parity
   end

   assign err_any    = ecc_en & (ecc_check != 7'd0);
   assign single_err = err_any & ecc_check[6];
   assign double_err = err_any & ~ecc_check[6];
   assign par_only   = single_err & (ecc_check == 7'b100_0000);   // only the parity bit flipped

   // one hot flip position in the 39 bit codeword
   always_comb begin
      for (int i = 1; i <= 39; i++) begin
         err_mask[i-1] = ecc_check[5:0] == i[5:0];
      end
   end

   // check bits sit at the power of two positions
   assign cw = {recc[6], rdata[31:26], recc[5], rdata[25:11], recc[4], rdata[10:4],
                recc[3], rdata[3:1], recc[2], rdata[0], recc[1:0]};

   assign cw_fix = single_err ? (cw ^ err_mask) : cw;

   assign data_fix = {cw_fix[37:32], cw_fix[30:16], cw_fix[14:8], cw_fix[6:4], cw_fix[2]};
   assign ecc_fix  = {cw_fix[38] ^ par_only, cw_fix[31], cw_fix[15], cw_fix[7],
                      cw_fix[3], cw_fix[1:0]};

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         d_valid  <= 1'b0;
         d_single <= 1'b0;
         d_double <= 1'b0;
      end else begin
         d_valid <= req_valid;
         if (req_valid) begin
            d_single <= single_err;
            d_double <= double_err;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) begin
         d_data <= data_fix;
         d_ecc  <= ecc_fix;
      end
   end

endmodule

//--- logic/ccm_load_resp.sv
`timescale 1ns/10ps

module ccm_load_resp (
   input  logic                          clk,
   input  logic                          rst_l,
   input  logic                          a_valid,
   input  ccm_pkg::addr_t                a_addr,
   input  logic                          a_in_range,
   input  logic                          a_in_region,
   input  logic                          d_valid,
   input  ccm_pkg::data_t                d_data,
   input  ccm_pkg::ecc_t                 d_ecc,
   input  logic                          d_single,
   input  logic                          d_double,
   output logic                          resp_valid,
   output ccm_pkg::addr_t                resp_addr,
   output ccm_pkg::data_t                resp_data,
   output ccm_pkg::ecc_t                 resp_ecc,
   output logic                          single_err,
   output logic                          double_err,
   output logic                          access_fault,
   output logic [ccm_pkg::ERR_CNT_W-1:0] single_err_count
);

   logic cnt_inc;

   // count only real single errors and stop at all ones
   assign cnt_inc = d_valid & d_single & ~(&single_err_count);

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         resp_valid       <= 1'b0;
         single_err       <= 1'b0;
         double_err       <= 1'b0;
         access_fault     <= 1'b0;
         single_err_count <= '0;
      end else begin
         resp_valid   <= a_valid;
         single_err   <= d_valid & d_single;
         double_err   <= d_valid & d_double;
         access_fault <= a_valid & a_in_region & ~a_in_range;   // ccm region but past the end
         if (cnt_inc) single_err_count <= single_err_count + 1'b1;
      end
   end

   // address and data sides each hold on their own strobe
   always_ff @(posedge clk) begin
      if (a_valid) resp_addr <= a_addr;
      if (d_valid) begin
         resp_data <= d_data;
         resp_ecc  <= d_ecc;
      end
   end

endmodule

//--- logic/ccm_load_top.sv
`timescale 1ns/10ps

module ccm_load_top (
   input  logic                          clk,
   input  logic                          rst_l,
   input  logic                          req_valid,
   input  ccm_pkg::addr_t                rs1,
   input  ccm_pkg::offset_t              offset,
   input  ccm_pkg::data_t                rdata,
   input  ccm_pkg::ecc_t                 recc,
   input  logic                          sed_ded,
   input  logic                          ecc_en,
   output logic                          resp_valid,
   output ccm_pkg::addr_t                resp_addr,
   output ccm_pkg::data_t                resp_data,
   output ccm_pkg::ecc_t                 resp_ecc,
   output logic                          single_err,
   output logic                          double_err,
   output logic                          access_fault,
   output logic [ccm_pkg::ERR_CNT_W-1:0] single_err_count
);

   // address stage results
   logic           a_valid;
   ccm_pkg::addr_t a_addr;
   logic           a_in_range;
   logic           a_in_region;

   // data stage results
   logic           d_valid;
   ccm_pkg::data_t d_data;
   ccm_pkg::ecc_t  d_ecc;
   logic           d_single;
   logic           d_double;

   ccm_addr_gen i_ccm_addr_gen (
      .clk, .rst_l, .req_valid, .rs1, .offset,
      .a_valid, .a_addr, .a_in_range, .a_in_region
   );

   ccm_ecc_check i_ccm_ecc_check (
      .clk, .rst_l, .req_valid, .ecc_en, .sed_ded, .rdata, .recc,
      .d_valid, .d_data, .d_ecc, .d_single, .d_double
   );

   // joins both paths one cycle later
   ccm_load_resp i_ccm_load_resp (
      .clk, .rst_l,
      .a_valid, .a_addr, .a_in_range, .a_in_region,
      .d_valid, .d_data, .d_ecc, .d_single, .d_double,
      .resp_valid, .resp_addr, .resp_data, .resp_ecc,
      .single_err, .double_err, .access_fault, .single_err_count
   );

endmodule

//--- tb/ccm_load_properties.sv
`timescale 1ns/10ps

module ccm_load_properties (
   input logic                          clk,
   input logic                          rst_l,
   input logic                          req_valid,
   input logic                          a_valid,
   input logic                          d_valid,
   input logic                          resp_valid,
   input logic                          single_err,
   input logic                          double_err,
   input logic [ccm_pkg::ERR_CNT_W-1:0] single_err_count
);

   // both paths sample the same strobe
   stage_valids_match: assert property (@(posedge clk) disable iff (!rst_l)
      a_valid == d_valid)
      else $error("address and data stage valids differ");

   flags_exclusive: assert property (@(posedge clk) disable iff (!rst_l)
      !(single_err && double_err))
      else $error("single and double error flags both high");

   resp_two_cycles: assert property (@(posedge clk) disable iff (!rst_l)
      resp_valid == $past(req_valid, 2))   // fixed two cycle latency
      else $error("resp_valid does not follow req_valid by two cycles");

   count_no_decrease: assert property (@(posedge clk) disable iff (!rst_l)
      single_err_count >= $past(single_err_count))
      else $error("single error count went down");

endmodule

bind ccm_load_top ccm_load_properties i_ccm_load_properties (
   .clk              (clk),
   .rst_l            (rst_l),
   .req_valid        (req_valid),
   .a_valid          (a_valid),
   .d_valid          (d_valid),
   .resp_valid       (resp_valid),
   .single_err       (single_err),
   .double_err       (double_err),
   .single_err_count (single_err_count)
);

//--- tb/ccm_load_tb.sv
`timescale 1ns/10ps

module ccm_load_tb;

   typedef struct packed {
      logic [31:0] base;
      logic [11:0] off;
      logic [31:0] data;       // clean word with check bits from the encoder
      logic [31:0] flip_d;
      logic [6:0]  flip_e;
      logic        sed;
      logic        en;
      logic [31:0] exp_addr;
      logic        exp_rng;
      logic        exp_reg;
      logic        exp_s;
      logic        exp_d;
      logic [31:0] exp_data;
   } row_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
      logic [6:0]  ecc;
      logic        single;
      logic        dbl;
      logic        fault;
   } resp_t;

   logic                          clk;
   logic                          rst_l;
   logic                          req_valid;
   ccm_pkg::addr_t                rs1;
   ccm_pkg::offset_t              offset;
   ccm_pkg::data_t                rdata;
   ccm_pkg::ecc_t                 recc;
   logic                          sed_ded;
   logic                          ecc_en;
   logic                          resp_valid;
   ccm_pkg::addr_t                resp_addr;
   ccm_pkg::data_t                resp_data;
   ccm_pkg::ecc_t                 resp_ecc;
   logic                          single_err;
   logic                          double_err;
   logic                          access_fault;
   logic [ccm_pkg::ERR_CNT_W-1:0] single_err_count;

   integer     seed = 32'hcce9d93c;
   resp_t      exp_q[$];
   resp_t      exp_now;
   logic [1:0] vhist = 2'b00;     // req_valid seen on the last two falling edges
   int         cnt_model = 0;

   // stimulus columns are base, offset, clean word, data flips, check flips, sed_ded, ecc_en
   // expected columns are address, in range, in region, single, double, data
   row_t stim_table [14] = '{
      '{32'hF004_0100, 12'h010, 32'hDEAD_BEEF, 32'h0000_0000, 7'h00, 1'b0, 1'b1,
        32'hF004_0110, 1'b1, 1'b1, 1'b0, 1'b0, 32'hDEAD_BEEF},
      '{32'hF004_0FF0, 12'h020, 32'h1234_5678, 32'h0000_0001, 7'h00, 1'b0, 1'b1,
        32'hF004_1010, 1'b1, 1'b1, 1'b1, 1'b0, 32'h1234_5678},
      '{32'hF004_1008, 12'hFF0, 32'hA5A5_5A5A, 32'h0000_0000, 7'h04, 1'b0, 1'b1,
        32'hF004_0FF8, 1'b1, 1'b1, 1'b1, 1'b0, 32'hA5A5_5A5A},
      '{32'hF004_0000, 12'h800, 32'hFFFF_FFFF, 32'h0000_0000, 7'h40, 1'b0, 1'b1,
        32'hF003_F800, 1'b0, 1'b1, 1'b1, 1'b0, 32'hFFFF_FFFF},
      '{32'hF005_0000, 12'h004, 32'h0000_0000, 32'h8000_0000, 7'h00, 1'b0, 1'b1,
        32'hF005_0004, 1'b0, 1'b1, 1'b1, 1'b0, 32'h0000_0000},
      '{32'hF004_FFFC, 12'h7FF, 32'h8000_0001, 32'h0000_0300, 7'h00, 1'b0, 1'b1,
        32'hF005_07FB, 1'b0, 1'b1, 1'b0, 1'b1, 32'h8000_0301},
      '{32'h2000_0000, 12'h100, 32'h1234_5678, 32'h0001_0000, 7'h01, 1'b0, 1'b1,
        32'h2000_0100, 1'b0, 1'b0, 1'b0, 1'b1, 32'h1235_5678},
      '{32'h0000_0800, 12'hFFF, 32'hDEAD_BEEF, 32'h0000_0010, 7'h00, 1'b1, 1'b1,
        32'h0000_07FF, 1'b0, 1'b0, 1'b0, 1'b1, 32'hDEAD_BEFF},
      '{32'hF004_2000, 12'h000, 32'hCAFE_F00D, 32'h0000_0000, 7'h20, 1'b1, 1'b1,
        32'hF004_2000, 1'b1, 1'b1, 1'b0, 1'b1, 32'hCAFE_F00D},
      '{32'hF004_3000, 12'h00C, 32'hCAFE_F00D, 32'h0000_0000, 7'h00, 1'b1, 1'b1,
        32'hF004_300C, 1'b1, 1'b1, 1'b0, 1'b0, 32'hCAFE_F00D},
      '{32'hF004_4000, 12'h004, 32'h0F0F_F0F0, 32'h0000_8000, 7'h00, 1'b0, 1'b0,
        32'hF004_4004, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0F0F_70F0},
      '{32'hFFFF_FFF0, 12'h020, 32'h5555_AAAA, 32'h4000_0000, 7'h00, 1'b0, 1'b1,
        32'h0000_0010, 1'b0, 1'b0, 1'b1, 1'b0, 32'h5555_AAAA},
      '{32'h0000_0004, 12'hFF8, 32'h0000_0000, 32'h0000_0000, 7'h00, 1'b0, 1'b0,
        32'hFFFF_FFFC, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0000_0000},
      '{32'hF004_FFF0, 12'h00F, 32'h3C3C_C3C3, 32'h0000_0000, 7'h01, 1'b0, 1'b1,
        32'hF004_FFFF, 1'b1, 1'b1, 1'b1, 1'b0, 32'h3C3C_C3C3}
   };

   ccm_load_top i_ccm_load_top (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // data bits fill codeword positions 1..38 that are not powers of two
   function automatic ccm_pkg::ecc_t hamming_encode(input ccm_pkg::data_t data);
      logic [31:0] word;
      logic [5:0]  syn;
      logic [5:0]  p;
      syn  = '0;
      word = data;
      for (int pos = 1; pos <= 38; pos++) begin
         p = 6'(pos);
         if ((p & (p - 6'd1)) != 6'd0) begin
            syn  = syn ^ (p & {6{word[0]}});   // each set position bit picks a check bit
            word = word >> 1;
         end
      end
      return {^{data, syn}, syn};   // overall parity on top
   endfunction

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL time %0t: %s got %h expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic send_req(input logic [31:0] base, input logic [11:0] off,
                           input logic [31:0] data, input logic [31:0] flip_d,
                           input logic [6:0] flip_e, input logic sed, input logic en,
                           input resp_t exp);
      @(posedge clk);
      req_valid <= 1'b1;
      rs1       <= base;
      offset    <= off;
      rdata     <= data ^ flip_d;
      recc      <= hamming_encode(data) ^ flip_e;
      sed_ded   <= sed;
      ecc_en    <= en;
      exp_q.push_back(exp);
   endtask

   task automatic run_table();
      row_t  row;
      resp_t e;
      foreach (stim_table[i]) begin
         row      = stim_table[i];
         e.addr   = row.exp_addr;
         e.data   = row.exp_data;
         e.ecc    = hamming_encode(row.data);
         if (!row.exp_s) e.ecc = e.ecc ^ row.flip_e;   // check bits pass through uncorrected
         e.single = row.exp_s;
         e.dbl    = row.exp_d;
         e.fault  = row.exp_reg & ~row.exp_rng;
         send_req(row.base, row.off, row.data, row.flip_d, row.flip_e, row.sed, row.en, e);
      end
   endtask

   task automatic run_random(input int count);
      logic [31:0] r;
      logic [31:0] base;
      logic [11:0] off;
      logic [31:0] data;
      logic [31:0] flip_d;
      logic [6:0]  flip_e;
      int          pos;
      resp_t       e;
      for (int n = 0; n < count; n++) begin
         base = $random(seed);
         if (base[0]) base[31:16] = 16'hF004;   // about half land in the ccm window
         r      = $random(seed);
         off    = r[11:0];
         data   = $random(seed);
         flip_d = '0;
         flip_e = '0;
         pos    = int'(r[21:16]) % 39;
         if (n % 16 != 0) begin
            if (pos < 32) flip_d = 32'd1 << pos;
            else flip_e = 7'd1 << (pos - 32);
         end
         e.addr   = base + {{20{off[11]}}, off};
         e.data   = data;
         e.ecc    = hamming_encode(data);
         e.single = (n % 16 != 0);
         e.dbl    = 1'b0;
         e.fault  = (e.addr[31:28] == 4'hF) && (e.addr[31:16] != 16'hF004);
         send_req(base, off, data, flip_d, flip_e, 1'b0, 1'b1, e);
      end
   endtask

   // outputs are settled at the falling edge
   always @(negedge clk) begin
      check_value("resp_valid", 32'(resp_valid), 32'(vhist[1]));
      if (resp_valid) begin
         if (exp_q.size() == 0) begin
            $display("response at %0t without an outstanding request", $time);
            stop_run();
         end else begin
            exp_now = exp_q.pop_front();
            if (exp_now.single && cnt_model < 255) cnt_model++;
            check_value("resp_addr", resp_addr, exp_now.addr);
            check_value("resp_data", resp_data, exp_now.data);
            check_value("resp_ecc", 32'(resp_ecc), 32'(exp_now.ecc));
            check_value("single_err", 32'(single_err), 32'(exp_now.single));
            check_value("double_err", 32'(double_err), 32'(exp_now.dbl));
            check_value("access_fault", 32'(access_fault), 32'(exp_now.fault));
         end
      end else begin
         check_value("single_err", 32'(single_err), 32'd0);
         check_value("double_err", 32'(double_err), 32'd0);
         check_value("access_fault", 32'(access_fault), 32'd0);
      end
      check_value("single_err_count", 32'(single_err_count), 32'(cnt_model));
      vhist = {vhist[0], req_valid};
   end

   initial begin
      rst_l     = 1'b0;
      req_valid = 1'b0;
      rs1       = '0;
      offset    = '0;
      rdata     = '0;
      recc      = '0;
      sed_ded   = 1'b0;
      ecc_en    = 1'b0;
      repeat (10) @(posedge clk);
      rst_l <= 1'b1;

      run_table();
      repeat (3) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
      run_random(300);   // enough single errors to reach saturation
      @(posedge clk);
      req_valid <= 1'b0;

      for (int t = 0; t < 20 && exp_q.size() != 0; t++) @(posedge clk);
      if (exp_q.size() != 0) begin
         $display("timeout, %0d responses never arrived", exp_q.size());
         stop_run();
      end else begin
         check_value("single_err_count", 32'(single_err_count), 32'd255);
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

//--- flist.f
logic/ccm_pkg.sv
logic/ccm_addr_gen.sv
logic/ccm_ecc_check.sv
logic/ccm_load_resp.sv
logic/ccm_load_top.sv
tb/ccm_load_properties.sv
tb/ccm_load_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the ccm load-check testbench with verilator and run it
# the exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
   verilator --binary --timing --assert -f flist.f --top-module ccm_load_tb \
      -o ccm_load_sim &&
   ./obj_dir/ccm_load_sim ||
   { echo "ccm_load build or simulation failed"; exit 1; }
